/* dv/retire_patterns.txt */
# cycles valid w0 arch0 phys0 w1 arch1 phys1 alloc_req query_arch, then the expected
# query_phys alloc_valid alloc_phys free_count after the last cycle; all fields hex
# identity map after seeding, 32 free
1 0 0 00 00 0 00 00 0 00  00 1 20 20
1 0 0 00 00 0 00 00 0 1f  1f 1 20 20
# single retire, arch 5 takes phys 32
1 0 0 00 00 0 00 00 1 05  05 1 21 1f
1 1 1 05 20 0 00 00 0 05  20 1 21 20
# two different destinations
2 0 0 00 00 0 00 00 1 05  20 1 23 1e
1 3 1 07 21 1 09 22 0 07  21 1 23 20
1 0 0 00 00 0 00 00 0 09  22 1 23 20
# both slots on arch 3, slot 1 wins
2 0 0 00 00 0 00 00 1 03  03 1 25 1e
1 3 1 03 23 1 03 24 0 03  24 1 25 20
# drain the list, releases come out as 5 7 9 3 35
1b 0 0 00 00 0 00 00 1 03  24 1 05 05
1 0 0 00 00 0 00 00 1 03  24 1 07 04
1 0 0 00 00 0 00 00 1 03  24 1 09 03
1 0 0 00 00 0 00 00 1 03  24 1 03 02
1 0 0 00 00 0 00 00 1 03  24 1 23 01
1 0 0 00 00 0 00 00 1 03  24 0 00 00
# request while empty, then entries without a destination
2 0 0 00 00 0 00 00 1 03  24 0 00 00
1 3 0 03 3a 0 09 3b 0 03  24 0 00 00
# a release refills the empty list
1 1 1 0c 25 0 00 00 0 0c  25 1 0c 01
1 0 0 00 00 0 00 00 0 07  21 1 0c 01
1 0 0 00 00 0 00 00 0 09  22 1 0c 01

/* dv/retire_rat_tb.sv */
`timescale 1ns/1ps
`include "retire_params.svh"

module retire_rat_tb
    import reg_pkg::*, rob_pkg::*;
();

    localparam int CLK_PERIOD = 4;

    // one line of the pattern file
    typedef struct packed {
        logic [15:0]   cycles;
        logic [1:0]    valid;
        retire_entry_t entry0;
        retire_entry_t entry1;
        logic          req;
        arch_reg_t     query;
        phys_reg_t     exp_query_phys;
        logic          exp_alloc_valid;
        phys_reg_t     exp_alloc_phys;
        free_count_t   exp_free_count;
    } step_t;

    logic                                clk;
    logic                                rst;
    logic          [`RETIRE_WIDTH-1:0]   retire_valid;
    retire_entry_t [`RETIRE_WIDTH-1:0]   retire_entry;
    logic                                alloc_req;
    arch_reg_t                           query_arch;
    logic                                ready;
    logic                                alloc_valid;
    phys_reg_t                           alloc_phys;
    free_count_t                         free_count;
    phys_reg_t                           query_phys;

    step_t steps[$];
    int    total_cycles;
    int    cur_step;
    bit    loaded;

    retire_rat UUT (
        .clk          (clk),
        .rst          (rst),
        .retire_valid (retire_valid),
        .retire_entry (retire_entry),
        .alloc_req    (alloc_req),
        .query_arch   (query_arch),
        .ready        (ready),
        .alloc_valid  (alloc_valid),
        .alloc_phys   (alloc_phys),
        .free_count   (free_count),
        .query_phys   (query_phys)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s at step %0d: got %h, expected %h",
                                     name, cur_step, actual, expected));
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          n_read;
        string       line;
        logic [31:0] cyc, rv, w0, a0, p0, w1, a1, p1;
        logic [31:0] rq, qa, eqp, eav, eap, efc;
        step_t       s;
        fd = $fopen("dv/retire_patterns.txt", "r");
        if (fd == 0) begin
            report_failure("could not open the pattern file dv/retire_patterns.txt");
        end
        while ($fgets(line, fd) != 0) begin
            // comment and blank lines
            if (line.len() < 2 || line.getc(0) == 8'h23) begin
                continue;
            end
            n_read = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             cyc, rv, w0, a0, p0, w1, a1, p1, rq, qa, eqp, eav, eap, efc);
            if (n_read != 14) begin
                report_failure($sformatf("pattern line has the wrong number of fields: %s",
                                         line));
            end
            s.cycles          = cyc[15:0];
            s.valid           = rv[1:0];
            s.entry0          = {w0[0], arch_reg_t'(a0), phys_reg_t'(p0)};
            s.entry1          = {w1[0], arch_reg_t'(a1), phys_reg_t'(p1)};
            s.req             = rq[0];
            s.query           = arch_reg_t'(qa);
            s.exp_query_phys  = phys_reg_t'(eqp);
            s.exp_alloc_valid = eav[0];
            s.exp_alloc_phys  = phys_reg_t'(eap);
            s.exp_free_count  = free_count_t'(efc);
            steps.push_back(s);
            total_cycles += int'(cyc[15:0]);
        end
        $fclose(fd);
        if (steps.size() == 0) begin
            report_failure("the pattern file holds no steps");
        end
    endtask

    // hold one step for its cycle count and then look at the outputs
    task automatic apply_step(input step_t s);
        retire_valid    = s.valid;
        retire_entry[0] = s.entry0;
        retire_entry[1] = s.entry1;
        alloc_req       = s.req;
        query_arch      = s.query;
        repeat (s.cycles) @(negedge clk);
        // the unit stays in run once seeding is over
        compare_value("ready", 32'(ready), 32'h1);
        compare_value("query_phys", 32'(query_phys), 32'(s.exp_query_phys));
        compare_value("alloc_valid", 32'(alloc_valid), 32'(s.exp_alloc_valid));
        compare_value("free_count", 32'(free_count), 32'(s.exp_free_count));
        // head is meaningless once the list is empty
        if (s.exp_alloc_valid) begin
            compare_value("alloc_phys", 32'(alloc_phys), 32'(s.exp_alloc_phys));
        end
    endtask

    // watchdog sized from the pattern cycles plus reset and seeding
    initial begin
        wait (loaded);
        #((total_cycles + 64) * CLK_PERIOD * 4);
        report_failure("timed out, the DUT never finished the pattern sequence");
    end

    initial begin
        rst          = 1'b1;
        retire_valid = '0;
        retire_entry = '0;
        alloc_req    = 1'b0;
        query_arch   = '0;
        cur_step     = 0;
        load_patterns();
        loaded = 1'b1;
        repeat (5) @(negedge clk);
        compare_value("ready", 32'(ready), 32'h0);
        compare_value("alloc_valid", 32'(alloc_valid), 32'h0);
        compare_value("free_count", 32'(free_count), 32'h0);
        rst = 1'b0;
        while (ready !== 1'b1) begin
            @(negedge clk);
        end
        for (int i = 0; i < steps.size(); i++) begin
            cur_step = i + 1;
            apply_step(steps[i]);
        end
        retire_valid = '0;
        alloc_req    = 1'b0;
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* retire_rat.f */
+incdir+source
source/reg_pkg.sv
source/rob_pkg.sv
source/retire_ctrl.sv
source/init_counter.sv
source/rrat.sv
source/free_list.sv
source/retire_rat.sv
dv/retire_rat_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f retire_rat.f --top-module retire_rat_tb \
    -o retire_rat_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/retire_rat_sim > sim.log 2>&1
grep -q "=== FAIL ===" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "no verdict found in sim.log"; exit 1; }
echo "simulation passed"
exit 0

/* source/free_list.sv */
`timescale 1ns/1ps
`include "retire_params.svh"

module free_list
    import reg_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             run_en,
    input  logic                             seed_valid,
    input  phys_reg_t                        seed_phys,
    input  logic      [`RETIRE_WIDTH-1:0]    release_valid,
    input  phys_reg_t [`RETIRE_WIDTH-1:0]    release_phys,
    input  logic                             alloc_req,
    output logic                             alloc_valid,
    output phys_reg_t                        alloc_phys,
    output free_count_t                      free_count
);

    phys_reg_t   mem [`NUM_PHYS_REGS];
    phys_reg_t   head;
    phys_reg_t   tail;
    free_count_t count;
    logic        push0;
    logic        push1;
    logic        pop;
    phys_reg_t   push0_phys;

    // port 0 belongs to the seed counter until the unit is running
    assign push0      = run_en ? release_valid[0] : seed_valid;
    assign push0_phys = run_en ? release_phys[0] : seed_phys;
    assign push1      = run_en && release_valid[1];

    // not empty; the top gates this with ready
    assign alloc_valid = (count != '0);
    assign pop         = run_en && alloc_req && alloc_valid;

    assign alloc_phys = mem[head];
    assign free_count = count;

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // pointers wrap naturally, depth is a power of two
            tail  <= tail + phys_reg_t'(push0) + phys_reg_t'(push1);
            head  <= head + phys_reg_t'(pop);
            count <= count + free_count_t'(push0) + free_count_t'(push1)
                     - free_count_t'(pop);
        end
    end

    // slot 0 lands first, slot 1 right behind it
    always_ff @(posedge clk) begin
        if (push0) begin
            mem[tail] <= push0_phys;
        end
        if (push1) begin
            mem[tail + phys_reg_t'(push0)] <= release_phys[1];
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (rst)
        count <= free_count_t'(`NUM_PHYS_REGS));

    // an empty list with nothing pushed must stay empty
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        (count == '0 && !push0 && !push1) |=> (count == '0));

endmodule

/* source/init_counter.sv */
`timescale 1ns/1ps
`include "retire_params.svh"

module init_counter
    import reg_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      seed_start,
    output logic      seed_valid,
    output phys_reg_t seed_phys,
    output logic      seed_done
);

    // registers above the identity mapping are free at reset
    localparam phys_reg_t FIRST_SEED = phys_reg_t'(`NUM_ARCH_REGS);
    localparam phys_reg_t LAST_SEED  = phys_reg_t'(`NUM_PHYS_REGS - 1);

    logic      active;
    phys_reg_t count;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            count  <= FIRST_SEED;
        end else if (seed_start) begin
            active <= 1'b1;
            count  <= FIRST_SEED;
        end else if (active) begin
            if (seed_done) begin
                active <= 1'b0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    assign seed_valid = active;
    assign seed_phys  = count;
    assign seed_done  = active && (count == LAST_SEED);

    a_seed_range: assert property (@(posedge clk) disable iff (rst)
        seed_valid |-> (seed_phys >= FIRST_SEED));

endmodule

/* source/reg_pkg.sv */
`include "retire_params.svh"

package reg_pkg;

    // architectural register number
    typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] arch_reg_t;

    // physical register number
    typedef logic [$clog2(`NUM_PHYS_REGS)-1:0] phys_reg_t;

    // free list occupancy, needs to reach NUM_PHYS_REGS itself
    typedef logic [$clog2(`NUM_PHYS_REGS + 1)-1:0] free_count_t;

endpackage

/* source/retire_ctrl.sv */
`timescale 1ns/1ps

module retire_ctrl
    import rob_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          seed_done,
    output logic          seed_start,
    output logic          run_en,
    output retire_state_t state
);

    retire_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            ST_RESET: begin
                // leave reset on the first cycle rst is low
                state_next = ST_SEED;
            end
            ST_SEED: begin
                if (seed_done) begin
                    state_next = ST_RUN;
                end
            end
            ST_RUN: begin
                state_next = ST_RUN;
            end
            default: begin
                state_next = ST_RESET;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_RESET;
            seed_start <= 1'b0;
        end else begin
            state      <= state_next;
            // one cycle pulse, high in the first ST_SEED cycle
            seed_start <= (state == ST_RESET);
        end
    end

    assign run_en = (state == ST_RUN);

    // once running, only a reset brings the unit back
    a_run_sticky: assert property (@(posedge clk) disable iff (rst)
        (state == ST_RUN) |=> (state == ST_RUN));

endmodule

/* source/retire_params.svh */
`ifndef RETIRE_PARAMS_SVH
`define RETIRE_PARAMS_SVH

// architectural register file size
`define NUM_ARCH_REGS 32

// physical register file size, the free list holds at most this many
`define NUM_PHYS_REGS 64

// instructions retired per cycle
`define RETIRE_WIDTH 2

`endif

/* source/retire_rat.sv */
`timescale 1ns/1ps
`include "retire_params.svh"

module retire_rat
    import reg_pkg::*, rob_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic          [`RETIRE_WIDTH-1:0]    retire_valid,
    input  retire_entry_t [`RETIRE_WIDTH-1:0]    retire_entry,
    input  logic                                 alloc_req,
    input  arch_reg_t                            query_arch,
    output logic                                 ready,
    output logic                                 alloc_valid,
    output phys_reg_t                            alloc_phys,
    output free_count_t                          free_count,
    output phys_reg_t                            query_phys
);

    retire_state_t                       state;
    logic                                seed_start;
    logic                                seed_valid;
    logic                                seed_done;
    logic                                run_en;
    logic                                list_valid;
    phys_reg_t                           seed_phys;
    logic      [`RETIRE_WIDTH-1:0]       release_valid;
    phys_reg_t [`RETIRE_WIDTH-1:0]       release_phys;

    assign ready       = (state == ST_RUN);
    assign alloc_valid = ready && list_valid;

    retire_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .seed_done  (seed_done),
        .seed_start (seed_start),
        .run_en     (run_en),
        .state      (state)
    );

    init_counter u_init (
        .clk        (clk),
        .rst        (rst),
        .seed_start (seed_start),
        .seed_valid (seed_valid),
        .seed_phys  (seed_phys),
        .seed_done  (seed_done)
    );

    rrat u_rrat (
        .clk           (clk),
        .rst           (rst),
        .run_en        (run_en),
        .retire_valid  (retire_valid),
        .retire_entry  (retire_entry),
        .query_arch    (query_arch),
        .query_phys    (query_phys),
        .release_valid (release_valid),
        .release_phys  (release_phys)
    );

    free_list u_free_list (
        .clk           (clk),
        .rst           (rst),
        .run_en        (run_en),
        .seed_valid    (seed_valid),
        .seed_phys     (seed_phys),
        .release_valid (release_valid),
        .release_phys  (release_phys),
        .alloc_req     (alloc_req),
        .alloc_valid   (list_valid),
        .alloc_phys    (alloc_phys),
        .free_count    (free_count)
    );

endmodule

/* source/rob_pkg.sv */
package rob_pkg;

    import reg_pkg::*;

    // one retiring instruction as seen by the rrat
    typedef struct packed {
        logic      writes_reg;
        arch_reg_t dst_arch;
        phys_reg_t dst_phys;
    } retire_entry_t;

    // control fsm states
    typedef enum logic [1:0] {
        ST_RESET,
        ST_SEED,
        ST_RUN
    } retire_state_t;

endpackage

/* source/rrat.sv */
`timescale 1ns/1ps
`include "retire_params.svh"

module rrat
    import reg_pkg::*, rob_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 run_en,
    input  logic          [`RETIRE_WIDTH-1:0]    retire_valid,
    input  retire_entry_t [`RETIRE_WIDTH-1:0]    retire_entry,
    input  arch_reg_t                            query_arch,
    output phys_reg_t                            query_phys,
    output logic          [`RETIRE_WIDTH-1:0]    release_valid,
    output phys_reg_t     [`RETIRE_WIDTH-1:0]    release_phys
);

    // committed arch -> phys mapping
    phys_reg_t                map_q [`NUM_ARCH_REGS];
    logic [`RETIRE_WIDTH-1:0] wr_en;
    logic                     same_dst;

    always_comb begin
        for (int i = 0; i < `RETIRE_WIDTH; i++) begin
            wr_en[i] = run_en && retire_valid[i] && retire_entry[i].writes_reg;
        end
    end

    // slot 1 sees slot 0's install when both hit the same register
    assign same_dst = wr_en[0] && (retire_entry[0].dst_arch == retire_entry[1].dst_arch);

    // the mapping being replaced goes back to the free list this edge
    always_comb begin
        release_valid   = wr_en;
        release_phys[0] = map_q[retire_entry[0].dst_arch];
        if (same_dst) begin
            release_phys[1] = retire_entry[0].dst_phys;
        end else begin
            release_phys[1] = map_q[retire_entry[1].dst_arch];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // identity mapping
            for (int a = 0; a < `NUM_ARCH_REGS; a++) begin
                map_q[a] <= phys_reg_t'(a);
            end
        end else begin
            // later slot overwrites, so slot 1 wins on a collision
            for (int i = 0; i < `RETIRE_WIDTH; i++) begin
                if (wr_en[i]) begin
                    map_q[retire_entry[i].dst_arch] <= retire_entry[i].dst_phys;
                end
            end
        end
    end

    assign query_phys = map_q[query_arch];

    // a register handed back while also being installed would be lost
    for (genvar s = 0; s < `RETIRE_WIDTH; s++) begin : g_release_chk
        a_release_ne_install: assert property (@(posedge clk) disable iff (rst)
            release_valid[s] |-> (release_phys[s] != retire_entry[s].dst_phys));
    end

endmodule
